// ==== Bender.yml ====
package:
  name: muldiv_unit

sources:
  - files:
      - src/muldiv_cfg_pkg.sv
      - src/muldiv_ops_pkg.sv
      - src/clz.sv
      - src/mul_unit.sv
      - src/div_unit.sv
      - src/muldiv_result_merge.sv
      - src/muldiv_unit.sv
  - target: test
    files:
      - tb/muldiv_unit_properties.sv
      - tb/muldiv_unit_tb.sv

// ==== muldiv_unit.f ====
src/muldiv_cfg_pkg.sv
src/muldiv_ops_pkg.sv
src/clz.sv
src/mul_unit.sv
src/div_unit.sv
src/muldiv_result_merge.sv
src/muldiv_unit.sv
tb/muldiv_unit_properties.sv
tb/muldiv_unit_tb.sv

// ==== src/clz.sv ====
`timescale 1ns/1ps
`default_nettype none

module clz #(
    parameter int XLEN = muldiv_cfg_pkg::XLEN_DEFAULT
) (
    input  wire  [XLEN-1:0]       clz_input,
    output logic [$clog2(XLEN):0] clz_out
);

    localparam int LG = $clog2(XLEN);

    // Node n of level l covers input bits [n*2^l +: 2^l]
    wire            all_zero   [LG+1][XLEN];
    wire [LG-1:0]   zero_count [LG+1][XLEN];

    for (genvar i = 0; i < XLEN; i++) begin : gen_leaf
        assign all_zero[0][i]   = ~clz_input[i];
        assign zero_count[0][i] = '0;
    end

    for (genvar l = 1; l <= LG; l++) begin : gen_level
        for (genvar n = 0; n < (XLEN >> l); n++) begin : gen_node
            assign all_zero[l][n] = all_zero[l-1][2*n+1] & all_zero[l-1][2*n];

            // An empty upper half adds its full width to the lower half's count
            assign zero_count[l][n] = all_zero[l-1][2*n+1]
                                    ? (zero_count[l-1][2*n] | LG'(1 << (l - 1)))
                                    : zero_count[l-1][2*n+1];
        end
    end

    assign clz_out = all_zero[LG][0] ? (LG + 1)'(XLEN) : {1'b0, zero_count[LG][0]};

endmodule

`default_nettype wire

// ==== src/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
    parameter int XLEN  = muldiv_cfg_pkg::XLEN_DEFAULT,
    parameter int TAG_W = muldiv_cfg_pkg::TAG_W_DEFAULT
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              start,
    input  wire  muldiv_ops_pkg::muldiv_op_t op,
    input  wire  [TAG_W-1:0]                 tag,
    input  wire  [XLEN-1:0]                  dividend,
    input  wire  [XLEN-1:0]                  divisor,
    input  wire                              result_taken,
    output logic                             busy,
    output logic                             done,
    output logic [XLEN-1:0]                  result,
    output logic [TAG_W-1:0]                 result_tag
);

    import muldiv_ops_pkg::*;

    localparam int CLZ_W = $clog2(XLEN) + 1;
    localparam int CNT_W = CLZ_W - 2;  // Holds half of the largest CLZ difference

    logic             signed_op;
    logic             dividend_neg;
    logic             divisor_neg;
    logic             div_by_zero;
    logic [XLEN-1:0]  abs_dividend;
    logic [XLEN-1:0]  abs_divisor;
    logic [CLZ_W-1:0] dividend_clz;
    logic [CLZ_W-1:0] divisor_clz;
    logic [CLZ_W:0]   clz_diff;
    logic             divisor_larger;
    logic             early_finish;

    logic [XLEN-1:0]  shifted_divisor;
    logic [XLEN-1:0]  quotient;
    logic [XLEN-1:0]  remainder;
    logic [XLEN+1:0]  sub_2x;
    logic [XLEN+1:0]  sub_1x;
    logic [1:0]       quotient_bits;
    logic [CNT_W-1:0] cycles_remaining;
    logic [CNT_W-1:0] cycles_next;
    logic             terminate;
    logic             running;
    logic             finish_q;

    logic             negate_quotient;
    logic             negate_remainder;
    logic             wants_remainder;
    logic [XLEN-1:0]  quotient_out;
    logic [XLEN-1:0]  remainder_out;

    function automatic logic [XLEN-1:0] negate_if(input logic [XLEN-1:0] value,
                                                   input logic neg);
        return neg ? (~value + 1'b1) : value;
    endfunction

    assign signed_op    = ~op_is_unsigned(op);
    assign dividend_neg = signed_op & dividend[XLEN-1];
    assign divisor_neg  = signed_op & divisor[XLEN-1];
    assign div_by_zero  = ~|divisor;
    assign abs_dividend = negate_if(dividend, dividend_neg);
    assign abs_divisor  = negate_if(divisor, divisor_neg);

    clz #(
        .XLEN(XLEN)
    ) dividend_clz_i (
        .clz_input(abs_dividend),
        .clz_out  (dividend_clz)
    );

    clz #(
        .XLEN(XLEN)
    ) divisor_clz_i (
        .clz_input(abs_divisor),
        .clz_out  (divisor_clz)
    );

    // A borrow means the divisor has a higher top bit than the dividend
    assign clz_diff       = {1'b0, divisor_clz} - {1'b0, dividend_clz};
    assign divisor_larger = clz_diff[CLZ_W];
    assign early_finish   = divisor_larger | div_by_zero;

    // Trial subtraction of 2d, then of d from whichever partial result is valid
    assign sub_2x = {2'b00, remainder} - {1'b0, shifted_divisor, 1'b0};
    assign sub_1x = sub_2x[XLEN+1] ? sub_2x + {2'b00, shifted_divisor}
                                   : sub_2x - {2'b00, shifted_divisor};
    assign quotient_bits = {~sub_2x[XLEN+1], ~sub_1x[XLEN+1]};

    assign {terminate, cycles_next} = {1'b0, cycles_remaining} - 1'b1;

    always_ff @(posedge clk) begin
        if (start) begin
            // An odd CLZ difference rounds down so each step retires a bit pair
            shifted_divisor  <= abs_divisor << {clz_diff[CLZ_W-2:1], 1'b0};
            cycles_remaining <= clz_diff[CLZ_W-2:1];
            quotient         <= div_by_zero ? '1 : '0;
            remainder        <= abs_dividend;
            negate_quotient  <= signed_op & (dividend[XLEN-1] ^ divisor[XLEN-1]) & ~div_by_zero;
            negate_remainder <= dividend_neg;  // Remainder takes the dividend's sign
            wants_remainder  <= op_wants_remainder(op);
            result_tag       <= tag;
        end else if (running) begin
            shifted_divisor  <= shifted_divisor >> 2;
            cycles_remaining <= cycles_next;
            quotient         <= {quotient[XLEN-3:0], quotient_bits};
            if (|quotient_bits) begin  // A zero pair leaves the remainder as it was
                remainder <= sub_1x[XLEN+1] ? sub_2x[XLEN-1:0] : sub_1x[XLEN-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            finish_q <= 1'b0;
            done     <= 1'b0;
            busy     <= 1'b0;
        end else begin
            running  <= (running & ~terminate) | (start & ~early_finish);
            finish_q <= (running & terminate) | (start & early_finish);
            if (finish_q) begin
                done <= 1'b1;
            end else if (result_taken) begin
                done <= 1'b0;
            end
            if (start) begin
                busy <= 1'b1;
            end else if (result_taken) begin
                busy <= 1'b0;
            end
        end
    end

    assign quotient_out  = negate_if(quotient, negate_quotient);
    assign remainder_out = negate_if(remainder, negate_remainder);

    // The result register keeps its value until the next finish
    always_ff @(posedge clk) begin
        if (finish_q) begin
            result <= wants_remainder ? remainder_out : quotient_out;
        end
    end

endmodule

`default_nettype wire

// ==== src/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
    parameter int XLEN  = muldiv_cfg_pkg::XLEN_DEFAULT,
    parameter int TAG_W = muldiv_cfg_pkg::TAG_W_DEFAULT
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              start,
    input  wire  muldiv_ops_pkg::muldiv_op_t op,
    input  wire  [TAG_W-1:0]                 tag,
    input  wire  [XLEN-1:0]                  rs1,
    input  wire  [XLEN-1:0]                  rs2,
    output logic                             valid,
    output logic [XLEN-1:0]                  result,
    output logic [TAG_W-1:0]                 result_tag
);

    import muldiv_ops_pkg::*;

    logic signed [XLEN:0]      rs1_ext;
    logic signed [XLEN:0]      rs2_ext;
    logic signed [2*XLEN+1:0]  full_product;

    logic                      stage1_valid;
    logic                      stage1_high;
    logic [TAG_W-1:0]          stage1_tag;
    logic [2*XLEN-1:0]         stage1_product;

    // One extra bit lets a single signed multiplier serve all sign mixes
    assign rs1_ext = {op_rs1_signed(op) & rs1[XLEN-1], rs1};
    assign rs2_ext = {op_rs2_signed(op) & rs2[XLEN-1], rs2};
    assign full_product = rs1_ext * rs2_ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_valid <= 1'b0;
            valid        <= 1'b0;
        end else begin
            stage1_valid <= start;
            valid        <= stage1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            stage1_product <= full_product[2*XLEN-1:0];
            stage1_high    <= op_wants_high(op);
            stage1_tag     <= tag;
        end
        if (stage1_valid) begin
            result     <= stage1_high ? stage1_product[2*XLEN-1:XLEN]
                                      : stage1_product[XLEN-1:0];
            result_tag <= stage1_tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/muldiv_cfg_pkg.sv ====
`default_nettype none

package muldiv_cfg_pkg;

    // Operand width of the core
    localparam int XLEN_DEFAULT = 32;

    localparam int TAG_W_DEFAULT = 4;  // Enough for the operations kept in flight

    // Cycles from a multiply start to mul_valid
    localparam int MUL_LATENCY = 2;

endpackage

`default_nettype wire

// ==== src/muldiv_ops_pkg.sv ====
`default_nettype none

package muldiv_ops_pkg;

    // Encoding follows funct3 of the M extension where bit 2 marks a divide
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_t;

    function automatic logic is_div_op(input muldiv_op_t op);
        return op[2];
    endfunction

    function automatic logic op_is_unsigned(input muldiv_op_t op);
        return op inside {OP_DIVU, OP_REMU};
    endfunction

    function automatic logic op_wants_remainder(input muldiv_op_t op);
        return op inside {OP_REM, OP_REMU};
    endfunction

    function automatic logic op_wants_high(input muldiv_op_t op);
        return op inside {OP_MULH, OP_MULHSU, OP_MULHU};
    endfunction

    // The low word of MUL does not depend on operand signs
    function automatic logic op_rs1_signed(input muldiv_op_t op);
        return op inside {OP_MULH, OP_MULHSU};
    endfunction

    function automatic logic op_rs2_signed(input muldiv_op_t op);
        return op == OP_MULH;
    endfunction

endpackage

`default_nettype wire

// ==== src/muldiv_result_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_result_merge #(
    parameter int XLEN  = muldiv_cfg_pkg::XLEN_DEFAULT,
    parameter int TAG_W = muldiv_cfg_pkg::TAG_W_DEFAULT
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               mul_valid,
    input  wire  [XLEN-1:0]   mul_result,
    input  wire  [TAG_W-1:0]  mul_tag,
    input  wire               div_done,
    input  wire  [XLEN-1:0]   div_result,
    input  wire  [TAG_W-1:0]  div_tag,
    output logic              result_taken,
    output logic              result_valid,
    output logic [XLEN-1:0]   result,
    output logic [TAG_W-1:0]  result_tag
);

    // The multiplier cannot stall, so the divider waits out a collision
    assign result_taken = div_done & ~mul_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= mul_valid | div_done;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_valid) begin
            result     <= mul_result;
            result_tag <= mul_tag;
        end else if (div_done) begin
            result     <= div_result;  // Held by the divider until taken
            result_tag <= div_tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/muldiv_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit #(
    parameter int XLEN  = muldiv_cfg_pkg::XLEN_DEFAULT,
    parameter int TAG_W = muldiv_cfg_pkg::TAG_W_DEFAULT
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              start,
    input  wire  muldiv_ops_pkg::muldiv_op_t op,
    input  wire  [TAG_W-1:0]                 tag,
    input  wire  [XLEN-1:0]                  rs1,
    input  wire  [XLEN-1:0]                  rs2,
    output logic                             div_busy,
    output logic                             result_valid,
    output logic [XLEN-1:0]                  result,
    output logic [TAG_W-1:0]                 result_tag
);

    import muldiv_ops_pkg::*;

    logic             mul_start;
    logic             div_start;
    logic             mul_valid;
    logic [XLEN-1:0]  mul_result;
    logic [TAG_W-1:0] mul_tag;
    logic             div_done;
    logic [XLEN-1:0]  div_result;
    logic [TAG_W-1:0] div_tag;
    logic             result_taken;

    // Both engines see the operands but only one of them gets the strobe
    assign mul_start = start & ~is_div_op(op);
    assign div_start = start & is_div_op(op);

    mul_unit #(
        .XLEN (XLEN),
        .TAG_W(TAG_W)
    ) mul_unit_i (
        .clk       (clk),
        .rst       (rst),
        .start     (mul_start),
        .op        (op),
        .tag       (tag),
        .rs1       (rs1),
        .rs2       (rs2),
        .valid     (mul_valid),
        .result    (mul_result),
        .result_tag(mul_tag)
    );

    div_unit #(
        .XLEN (XLEN),
        .TAG_W(TAG_W)
    ) div_unit_i (
        .clk         (clk),
        .rst         (rst),
        .start       (div_start),
        .op          (op),
        .tag         (tag),
        .dividend    (rs1),
        .divisor     (rs2),
        .result_taken(result_taken),
        .busy        (div_busy),
        .done        (div_done),
        .result      (div_result),
        .result_tag  (div_tag)
    );

    muldiv_result_merge #(
        .XLEN (XLEN),
        .TAG_W(TAG_W)
    ) result_merge_i (
        .clk         (clk),
        .rst         (rst),
        .mul_valid   (mul_valid),
        .mul_result  (mul_result),
        .mul_tag     (mul_tag),
        .div_done    (div_done),
        .div_result  (div_result),
        .div_tag     (div_tag),
        .result_taken(result_taken),
        .result_valid(result_valid),
        .result      (result),
        .result_tag  (result_tag)
    );

endmodule

`default_nettype wire

// ==== tb/muldiv_unit_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit_properties (
    input wire                             clk,
    input wire                             rst,
    input wire                             start,
    input wire muldiv_ops_pkg::muldiv_op_t op,
    input wire                             div_busy,
    input wire                             result_valid,
    input wire                             div_done,
    input wire                             result_taken
);

    import muldiv_ops_pkg::*;
    import muldiv_cfg_pkg::*;

    int failures = 0;

    // The divider holds a single operation and reports busy from the cycle after its start
    assert property (@(posedge clk) disable iff (rst)
                     start && is_div_op(op) |-> !div_busy ##1 div_busy)
        else begin
            $error("divide issued while the divider was busy or busy did not rise");
            failures++;
        end

    assert property (@(posedge clk) rst |=> !result_valid)
        else begin
            $error("result_valid high out of reset");
            failures++;
        end

    // A finished divide holds its result until the merge takes it
    assert property (@(posedge clk) disable iff (rst) div_done && !result_taken |=> div_done)
        else begin
            $error("divider result dropped before it was taken");
            failures++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     result_taken |-> div_done ##1 (!div_done && !div_busy))
        else begin
            $error("divider result taken while none was done or not released after");
            failures++;
        end

    // The multiplier never waits on the merge
    assert property (@(posedge clk) disable iff (rst)
                     start && !is_div_op(op) |-> ##(MUL_LATENCY + 1) result_valid)
        else begin
            $error("multiply result did not appear in time");
            failures++;
        end

endmodule

bind muldiv_unit muldiv_unit_properties protocol_checks (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .op          (op),
    .div_busy    (div_busy),
    .result_valid(result_valid),
    .div_done    (div_done),
    .result_taken(result_taken)
);

`default_nettype wire

// ==== tb/muldiv_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit_tb;

    import muldiv_ops_pkg::*;
    import muldiv_cfg_pkg::*;

    localparam int XLEN       = XLEN_DEFAULT;
    localparam int TAG_W      = TAG_W_DEFAULT;
    localparam int NUM_TAGS   = 1 << TAG_W;
    localparam int MAX_VEC    = 64;
    localparam int WAIT_LIMIT = 200;  // Cycles allowed for any single wait

    logic             clk;
    logic             rst;
    logic             start;
    muldiv_op_t       op;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  rs1;
    logic [XLEN-1:0]  rs2;
    logic             div_busy;
    logic             result_valid;
    logic [XLEN-1:0]  result;
    logic [TAG_W-1:0] result_tag;

    muldiv_op_t       vec_op  [MAX_VEC];
    logic [TAG_W-1:0] vec_tag [MAX_VEC];
    logic [XLEN-1:0]  vec_rs1 [MAX_VEC];
    logic [XLEN-1:0]  vec_rs2 [MAX_VEC];
    logic [XLEN-1:0]  vec_exp [MAX_VEC];
    int               num_vec;

    // Scoreboard by tag with the issue and return counts kept apart
    int               issued_count   [NUM_TAGS];
    int               returned_count [NUM_TAGS];
    int               vec_of_tag     [NUM_TAGS];
    logic [TAG_W-1:0] mul_issued     [MAX_VEC];  // Multiply tags in issue order
    int               mul_issued_n;
    int               mul_returned_n;
    int               issued_total;
    int               results_seen;
    int               errors;
    int               passed;
    logic [31:0]      lfsr;

    muldiv_unit #(
        .XLEN (XLEN),
        .TAG_W(TAG_W)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .op          (op),
        .tag         (tag),
        .rs1         (rs1),
        .rs2         (rs2),
        .div_busy    (div_busy),
        .result_valid(result_valid),
        .result      (result),
        .result_tag  (result_tag)
    );

    always #20 clk = ~clk;

    // Polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic idle_cycles_from_lfsr(output int cycles);
        cycles = 0;
        repeat (2) begin
            lfsr   = lfsr_step(lfsr);
            cycles = (cycles << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Run stopped at %0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic check_result(input string name, input logic [XLEN-1:0] actual,
                                input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input logic [TAG_W-1:0] actual,
                             input logic [TAG_W-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       word;
        string       rest;
        logic [2:0]  f_op;
        logic [TAG_W-1:0] f_tag;
        logic [XLEN-1:0]  f_rs1;
        logic [XLEN-1:0]  f_rs2;
        logic [XLEN-1:0]  f_exp;
        num_vec = 0;
        fd = $fopen("tb/muldiv_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tb/muldiv_vectors.txt");
        end else begin
            while ($fscanf(fd, "%s", word) == 1) begin
                if (word[0] == "#") begin
                    code = $fgets(rest, fd);  // Skip the rest of a comment line
                end else begin
                    code = $sscanf(word, "%h", f_op);
                    code += $fscanf(fd, "%h %h %h %h", f_tag, f_rs1, f_rs2, f_exp);
                    if (code != 5 || num_vec >= MAX_VEC) begin
                        $display("Vector file line after vector %0d could not be read",
                                 num_vec);
                        errors++;
                    end else begin
                        vec_op[num_vec]  = muldiv_op_t'(f_op);
                        vec_tag[num_vec] = f_tag;
                        vec_rs1[num_vec] = f_rs1;
                        vec_rs2[num_vec] = f_rs2;
                        vec_exp[num_vec] = f_exp;
                        num_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // The tag has to be free, and a divide also needs an idle divider
    function automatic logic issue_blocked(input int v);
        return issued_count[vec_tag[v]] != returned_count[vec_tag[v]]
               || (is_div_op(vec_op[v]) && div_busy);
    endfunction

    task automatic issue(input int v);
        int waited;
        waited = 0;
        while (issue_blocked(v) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (issue_blocked(v)) begin
            abort_run($sformatf("vector %0d waited too long to issue", v));
        end else begin
            start = 1'b1;
            op    = vec_op[v];
            tag   = vec_tag[v];
            rs1   = vec_rs1[v];
            rs2   = vec_rs2[v];
            vec_of_tag[vec_tag[v]] = v;
            issued_count[vec_tag[v]]++;
            if (!is_div_op(vec_op[v])) begin
                mul_issued[mul_issued_n] = vec_tag[v];
                mul_issued_n++;
            end
            issued_total++;
            @(posedge clk);
            #2;
            start = 1'b0;
        end
    endtask

    // Outputs settle after the rising edge, so they are read on the falling one
    always @(negedge clk) begin : monitor
        int v;
        int errors_before;
        if (rst || issued_total == 0) begin
            check_flag("result_valid", result_valid, 1'b0);
            check_flag("div_busy", div_busy, 1'b0);
        end else if (result_valid) begin
            if (issued_count[result_tag] == returned_count[result_tag]) begin
                $display("Error at %0t: a result with tag %h came with nothing outstanding",
                         $time, result_tag);
                errors++;
            end else begin
                v             = vec_of_tag[result_tag];
                errors_before = errors;
                returned_count[result_tag]++;
                results_seen++;
                check_result("result", result, vec_exp[v]);
                if (!is_div_op(vec_op[v])) begin
                    check_tag("result_tag", result_tag, mul_issued[mul_returned_n]);
                    mul_returned_n++;
                end
                if (errors == errors_before) begin
                    passed++;
                end
                $display("vector %0d %s tag %h result %h %s", v, vec_op[v].name(),
                         result_tag, result, (errors == errors_before) ? "ok" : "wrong");
            end
        end
    end

    initial begin : stimulus
        int gap;
        int waited;
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        op    = OP_MUL;
        tag   = '0;
        rs1   = '0;
        rs2   = '0;
        lfsr  = 32'h97443abd;
        errors         = 0;
        passed         = 0;
        results_seen   = 0;
        issued_total   = 0;
        mul_issued_n   = 0;
        mul_returned_n = 0;
        foreach (issued_count[i]) begin
            issued_count[i]   = 0;
            returned_count[i] = 0;
            vec_of_tag[i]     = 0;
        end
        load_vectors();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);  // One quiet cycle after reset is checked by the monitor
        #2;
        for (int v = 0; v < num_vec; v++) begin
            issue(v);
            idle_cycles_from_lfsr(gap);
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
        end
        waited = 0;
        while (results_seen < num_vec && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (results_seen < num_vec) begin
            abort_run($sformatf("only %0d of %0d results arrived", results_seen, num_vec));
        end else begin
            repeat (8) @(posedge clk);  // Room for any stray result pulse
            errors += DUT.protocol_checks.failures;
            $display("%0d vectors, %0d passed, %0d errors", num_vec, passed, errors);
            if (errors == 0 && num_vec > 0 && passed == num_vec) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/muldiv_vectors.txt ====
# op tag rs1 rs2 expected, all hex, one operation per line
# op: 0 MUL 1 MULH 2 MULHSU 3 MULHU 4 DIV 5 DIVU 6 REM 7 REMU
5 e ffffffff 00000001 ffffffff
0 0 00000007 00000006 0000002a
0 1 fffffffd 00000005 fffffff1
1 2 fffffffd 00000005 ffffffff
3 3 ffffffff ffffffff fffffffe
2 4 ffffffff ffffffff ffffffff
2 5 80000000 00010000 ffff8000
1 6 80000000 80000000 40000000
3 7 12345678 00000010 00000001
0 8 12345678 00000010 23456780
1 9 7fffffff 7fffffff 3fffffff
4 f 00000014 00000006 00000003
0 a 0000ffff 0000ffff fffe0001
4 e ffffffec 00000006 fffffffd
6 f ffffffec 00000006 fffffffe
3 b 0000ffff 0000ffff 00000000
6 e 00000014 fffffffa 00000002
4 f ffffffec fffffffa 00000003
5 e ffffffec 00000006 2aaaaaa7
7 f ffffffec 00000006 00000002
4 e 00001234 00000000 ffffffff
6 f ffffffec 00000000 ffffffec
5 e 00000005 00000000 ffffffff
7 f 80000000 00000000 80000000
4 e 80000000 ffffffff 80000000
6 f 80000000 ffffffff 00000000
7 e 00000005 00000007 00000005
6 f fffffffb 00000007 fffffffb
